//--- hw/mcpu_bus_pkg.sv
package mcpu_bus_pkg;

  // Word geometry
  localparam int BYTE_LANES = 4;              // Bytes per word
  localparam int WORD_BITS  = 8 * BYTE_LANES; // 32-bit data path
  localparam int ADDR_BITS  = 10;

  // Storage depth
  localparam int MEM_WORDS = 1 << ADDR_BITS;  // 1024 words

  // Cycles from an accepted read to read_valid
  localparam int READ_LATENCY = 2;

  // Word address, one step per 32-bit word
  typedef logic [ADDR_BITS-1:0] word_addr_t;

  // One data word on the bus
  typedef logic [WORD_BITS-1:0] word_t;

  // One bit per byte lane, bit 0 is bits 7..0
  typedef logic [BYTE_LANES-1:0] byte_en_t;

endpackage

//--- hw/mcpu_io_pkg.sv
package mcpu_io_pkg;

  // Serial receive
  localparam int UART_DATA_BITS = 8;  // 8N1 framing
  localparam int RX_SYNC_STAGES = 4;  // Pin to sampler
  localparam int KEY_SYNC_STAGES = 2; // Push buttons

  localparam int BYTE_PTR_BITS = 12;  // 4096 bytes of memory

  typedef logic [9:0] switch_t;
  typedef logic [9:0] led_r_t;
  typedef logic [7:0] led_g_t;
  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

  // Byte address, lane in the two low bits
  typedef logic [BYTE_PTR_BITS-1:0] byte_ptr_t;

endpackage

//--- hw/mem_bus_if.sv
`timescale 1ns/10ps

interface mem_bus_if;

  // Request side
  logic                     read_req;
  logic                     write_req;
  mcpu_bus_pkg::word_addr_t addr;
  mcpu_bus_pkg::byte_en_t   be;     // Only looked at on writes
  mcpu_bus_pkg::word_t      wdata;

  // Controller side
  logic                     ready;      // Low means back-pressure
  mcpu_bus_pkg::word_t      rdata;
  logic                     read_valid; // One-cycle strobe with rdata

  modport host (
    output read_req, write_req, addr, be, wdata,
    input  ready, rdata, read_valid
  );

  modport ctrl (
    input  read_req, write_req, addr, be, wdata,
    output ready, rdata, read_valid
  );

endinterface

//--- hw/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
  input  logic    clk50,
  input  logic    arst_n,
  mem_bus_if.ctrl lod,
  mem_bus_if.ctrl peek,
  mem_bus_if.host mc
);

  // At most READ_LATENCY reads can be in flight
  localparam int OWN_DEPTH = mcpu_bus_pkg::READ_LATENCY;
  localparam int PTR_W     = $clog2(OWN_DEPTH);
  localparam int CNT_W     = $clog2(OWN_DEPTH + 1);

  logic             lod_req;
  logic             peek_req;
  logic             gnt_peek;  // 1 grants peek, 0 grants lod
  logic             gnt_q;     // Last grant seen with a request
  logic             lock_q;    // Previous request stalled
  logic             mc_req;
  logic             push;
  logic             pop;
  logic             head_peek;
  logic             own_q [OWN_DEPTH]; // Read owner per accepted read
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] own_cnt_q;

  assign lod_req  = lod.read_req | lod.write_req;
  assign peek_req = peek.read_req | peek.write_req;

  always_comb begin
    if (lock_q) gnt_peek = gnt_q;                      // Hold through a stall
    else if (lod_req && peek_req) gnt_peek = ~gnt_q;   // Alternate
    else gnt_peek = peek_req;
  end

  // Request mux, no added latency
  assign mc.read_req  = gnt_peek ? peek.read_req  : lod.read_req;
  assign mc.write_req = gnt_peek ? peek.write_req : lod.write_req;
  assign mc.addr      = gnt_peek ? peek.addr      : lod.addr;
  assign mc.be        = gnt_peek ? peek.be        : lod.be;
  assign mc.wdata     = gnt_peek ? peek.wdata     : lod.wdata;

  assign lod.ready  = mc.ready & ~gnt_peek;
  assign peek.ready = mc.ready & gnt_peek;
  assign lod.rdata  = mc.rdata; // Shared, qualified by read_valid
  assign peek.rdata = mc.rdata;

  // Oldest accepted read owns the returning strobe
  assign head_peek       = own_q[rd_ptr_q];
  assign lod.read_valid  = mc.read_valid & ~head_peek;
  assign peek.read_valid = mc.read_valid & head_peek;

  assign mc_req = mc.read_req | mc.write_req;
  assign push   = mc.read_req & mc.ready;
  assign pop    = mc.read_valid;

  always_ff @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      gnt_q     <= 1'b0;
      lock_q    <= 1'b0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      own_cnt_q <= '0;
    end else begin
      if (mc_req) gnt_q <= gnt_peek;
      lock_q <= mc_req & ~mc.ready;
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) own_cnt_q <= own_cnt_q + 1'b1;
      else if (pop && !push) own_cnt_q <= own_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk50) begin
    if (push) own_q[wr_ptr_q] <= gnt_peek;
  end

  a_own_no_overflow: assert property (@(posedge clk50) disable iff (!arst_n)
    push && !pop |-> own_cnt_q < CNT_W'(OWN_DEPTH));

  // Host holds its request until accepted
  a_req_stable: assert property (@(posedge clk50) disable iff (!arst_n)
    mc_req && !mc.ready |=>
      $stable({mc.read_req, mc.write_req, mc.addr, mc.be, mc.wdata}));

endmodule

//--- hw/mem_ctrl.sv
`timescale 1ns/10ps

module mem_ctrl #(
  parameter int init_words = mcpu_bus_pkg::MEM_WORDS
) (
  input  logic    clk50,
  input  logic    arst_n,
  mem_bus_if.ctrl bus,
  output logic    mc_ready
);

  localparam int LAT = mcpu_bus_pkg::READ_LATENCY;

  // Last word the clearing sweep touches
  localparam mcpu_bus_pkg::word_addr_t SWEEP_LAST =
    mcpu_bus_pkg::word_addr_t'(init_words - 1);

  mcpu_bus_pkg::word_t      mem [mcpu_bus_pkg::MEM_WORDS];
  mcpu_bus_pkg::word_addr_t sweep_addr_q;
  mcpu_bus_pkg::word_addr_t rd_addr_q;  // Read stage 1
  mcpu_bus_pkg::word_t      rd_data_q;  // Read stage 2
  logic [LAT-1:0]           rd_vld_q;   // Valid per read stage
  logic                     wr_xfer;
  logic                     rd_xfer;

  assign bus.ready = mc_ready; // Always accepts once cleared
  assign wr_xfer   = bus.write_req & mc_ready;
  assign rd_xfer   = bus.read_req & mc_ready;

  // Clearing sweep, one word per cycle
  always_ff @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      sweep_addr_q <= '0;
      mc_ready     <= 1'b0;
    end else if (!mc_ready) begin
      sweep_addr_q <= sweep_addr_q + 1'b1;
      if (sweep_addr_q == SWEEP_LAST) mc_ready <= 1'b1; // Stays high
    end
  end

  // Storage port, sweep has the port until ready
  always_ff @(posedge clk50) begin
    if (!mc_ready) begin
      mem[sweep_addr_q] <= '0;
    end else if (wr_xfer) begin
      for (int i = 0; i < mcpu_bus_pkg::BYTE_LANES; i++) begin
        if (bus.be[i]) mem[bus.addr][8*i +: 8] <= bus.wdata[8*i +: 8];
      end
    end
  end

  // Read valid pipe
  always_ff @(posedge clk50 or negedge arst_n) begin
    if (!arst_n) begin
      rd_vld_q <= '0;
    end else begin
      rd_vld_q <= {rd_vld_q[LAT-2:0], rd_xfer};
    end
  end

  // Read data, address then array lookup
  always_ff @(posedge clk50) begin
    if (rd_xfer) rd_addr_q <= bus.addr;
    rd_data_q <= mem[rd_addr_q]; // Old data if written the same edge
  end

  assign bus.rdata      = rd_data_q;
  assign bus.read_valid = rd_vld_q[LAT-1];

  // Clients sit in reset until the sweep is over
  a_no_req_in_sweep: assert property (@(posedge clk50) disable iff (!arst_n)
    !mc_ready |-> !(bus.read_req || bus.write_req));

  a_one_req_kind: assert property (@(posedge clk50) disable iff (!arst_n)
    !(bus.read_req && bus.write_req));

endmodule

//--- hw/uart_loader.sv
`timescale 1ns/10ps

module uart_loader #(
  parameter int clks_per_bit = 8
) (
  input  logic    clk50,
  input  logic    core_rst_n,
  input  logic    uart_rx,
  mem_bus_if.host bus
);

  localparam int SYNC_N = mcpu_io_pkg::RX_SYNC_STAGES;
  localparam int NBITS  = mcpu_io_pkg::UART_DATA_BITS;
  localparam int CNT_W  = $clog2(clks_per_bit);
  localparam int BIT_W  = $clog2(NBITS);

  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(clks_per_bit / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(clks_per_bit - 1);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(NBITS - 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } rx_state_t;

  rx_state_t               state_q;
  logic [SYNC_N-1:0]       rx_sync_q;  // Pin enters at the top
  logic                    rx;
  logic [CNT_W-1:0]        clk_cnt_q;
  logic [BIT_W-1:0]        bit_idx_q;
  logic                    mid_sample; // Middle of a data or stop bit
  logic                    stop_ok;
  logic                    wr_pend_q;
  mcpu_io_pkg::uart_byte_t shift_q;
  mcpu_io_pkg::uart_byte_t wr_byte_q;  // Held while the write waits
  mcpu_io_pkg::byte_ptr_t  ptr_q;

  assign rx         = rx_sync_q[0];
  assign mid_sample = (clk_cnt_q == FULL_BIT);
  assign stop_ok    = (state_q == ST_STOP) && mid_sample && rx;

  always_ff @(posedge clk50 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      rx_sync_q <= '1; // Line idles high
      state_q   <= ST_IDLE;
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      wr_pend_q <= 1'b0;
      ptr_q     <= '0;
    end else begin
      rx_sync_q <= {uart_rx, rx_sync_q[SYNC_N-1:1]};
      case (state_q)
        ST_IDLE: begin
          clk_cnt_q <= '0;
          if (!rx) state_q <= ST_START;
        end
        ST_START: begin
          if (clk_cnt_q == HALF_BIT) begin
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
            state_q   <= rx ? ST_IDLE : ST_DATA; // Short glitch goes back
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_DATA: begin
          if (mid_sample) begin
            clk_cnt_q <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == LAST_BIT) state_q <= ST_STOP;
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        ST_STOP: begin
          if (mid_sample) begin
            clk_cnt_q <= '0;
            state_q   <= ST_IDLE; // Bad stop bit just drops the byte
          end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
      if (wr_pend_q && bus.ready) begin
        wr_pend_q <= 1'b0;
        ptr_q     <= ptr_q + 1'b1; // Wraps at 4096
      end
      if (stop_ok) wr_pend_q <= 1'b1;
    end
  end

  // Payload, LSB first
  always_ff @(posedge clk50) begin
    if (state_q == ST_DATA && mid_sample) shift_q <= {rx, shift_q[NBITS-1:1]};
    if (stop_ok) wr_byte_q <= shift_q;
  end

  assign bus.read_req  = 1'b0;
  assign bus.write_req = wr_pend_q;
  assign bus.addr      = ptr_q[11:2];                           // Word part
  assign bus.be        = mcpu_bus_pkg::byte_en_t'(1) << ptr_q[1:0]; // One lane
  assign bus.wdata     = {mcpu_bus_pkg::BYTE_LANES{wr_byte_q}};

endmodule

//--- hw/led_peek.sv
`timescale 1ns/10ps

module led_peek (
  input  logic                clk50,
  input  logic                core_rst_n,
  input  logic                key_n,
  input  mcpu_io_pkg::switch_t sw,
  mem_bus_if.host             bus,
  output mcpu_io_pkg::led_r_t led_r,
  output mcpu_io_pkg::led_g_t led_g
);

  localparam int SYNC_N = mcpu_io_pkg::KEY_SYNC_STAGES;

  logic [SYNC_N-1:0]        key_sync_q;
  logic                     key_prev_q;
  logic                     press;   // Falling edge of the button
  logic                     start;
  logic                     busy_q;  // Read outstanding
  logic                     rd_req_q;
  mcpu_bus_pkg::word_addr_t addr_q;

  assign press = key_prev_q & ~key_sync_q[SYNC_N-1];
  assign start = press & ~busy_q; // Extra presses ignored

  always_ff @(posedge clk50 or negedge core_rst_n) begin
    if (!core_rst_n) begin
      key_sync_q <= '1; // Released
      key_prev_q <= 1'b1;
      busy_q     <= 1'b0;
      rd_req_q   <= 1'b0;
      led_r      <= '0;
      led_g      <= '0;
    end else begin
      key_sync_q <= {key_sync_q[SYNC_N-2:0], key_n};
      key_prev_q <= key_sync_q[SYNC_N-1];
      if (start) begin
        busy_q   <= 1'b1;
        rd_req_q <= 1'b1;
      end else begin
        if (rd_req_q && bus.ready) rd_req_q <= 1'b0;
        if (bus.read_valid) begin
          busy_q <= 1'b0;
          led_r  <= bus.rdata[9:0];
          led_g  <= bus.rdata[17:10];
        end
      end
    end
  end

  // Address captured at the press
  always_ff @(posedge clk50) begin
    if (start) addr_q <= mcpu_bus_pkg::word_addr_t'(sw);
  end

  assign bus.read_req  = rd_req_q;
  assign bus.write_req = 1'b0;
  assign bus.addr      = addr_q;
  assign bus.be        = '1;
  assign bus.wdata     = '0;

endmodule

//--- hw/mcpu_top.sv
`timescale 1ns/10ps

module mcpu_top #(
  parameter int clks_per_bit = 8,
  parameter int init_words   = mcpu_bus_pkg::MEM_WORDS
) (
  input  logic                 clk50,
  input  logic                 arst_n,
  input  mcpu_io_pkg::switch_t SW,
  input  logic [3:0]           KEY,
  input  logic                 UART_RX,
  output mcpu_io_pkg::led_r_t  LEDR,
  output mcpu_io_pkg::led_g_t  LEDG,
  output logic                 mc_ready
);

  logic       core_rst_pre_n; // Any source holds the clients
  logic [1:0] core_rst_q;
  logic       core_rst_n;

  mem_bus_if lod_bus ();
  mem_bus_if peek_bus ();
  mem_bus_if mc_bus ();

  assign core_rst_pre_n = arst_n & mc_ready & KEY[0];

  // Asserts at once, releases on clk50
  always_ff @(posedge clk50 or negedge core_rst_pre_n) begin
    if (!core_rst_pre_n) core_rst_q <= '0;
    else core_rst_q <= {core_rst_q[0], 1'b1};
  end

  assign core_rst_n = core_rst_q[1];

  mem_ctrl #(.init_words(init_words)) mem_ctrl_i (
    .clk50    (clk50),
    .arst_n   (arst_n),   // Sweep starts off board reset only
    .bus      (mc_bus),
    .mc_ready (mc_ready)
  );

  mem_arbiter mem_arbiter_i (
    .clk50  (clk50),
    .arst_n (arst_n),
    .lod    (lod_bus),
    .peek   (peek_bus),
    .mc     (mc_bus)
  );

  uart_loader #(.clks_per_bit(clks_per_bit)) uart_loader_i (
    .clk50      (clk50),
    .core_rst_n (core_rst_n),
    .uart_rx    (UART_RX),
    .bus        (lod_bus)
  );

  led_peek led_peek_i (
    .clk50      (clk50),
    .core_rst_n (core_rst_n),
    .key_n      (KEY[1]),
    .sw         (SW),
    .bus        (peek_bus),
    .led_r      (LEDR),
    .led_g      (LEDG)
  );

endmodule

//--- verif/tb_tasks.svh
// 32-bit xorshift, state kept in rng_state
function automatic logic [31:0] next_random();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

task automatic wait_mc_ready();
  int n;
  n = 0;
  while (mc_ready !== 1'b1 && n < INIT_WORDS + 4) begin
    @(negedge clk50);
    n++;
  end
  if (mc_ready !== 1'b1) fail_timeout("mc_ready did not rise after the clearing sweep");
endtask

task automatic wait_core_release();
  int n;
  n = 0;
  while (mcpu_top_i.core_rst_n !== 1'b1 && n < 8) begin
    @(negedge clk50);
    n++;
  end
  if (mcpu_top_i.core_rst_n !== 1'b1) fail_timeout("the client reset never released");
endtask

task automatic pulse_core_reset();
  @(negedge clk50);
  KEY[0] = 1'b0;
  repeat (4) @(negedge clk50);
  KEY[0] = 1'b1;
  wait_core_release();
endtask

// 8N1 frame, then wait for the memory write
task automatic send_byte(input logic [7:0] data);
  int   n;
  logic got;
  n   = 0;
  got = 1'b0;
  @(negedge clk50);
  UART_RX = 1'b0; // Start bit
  repeat (CLKS_PER_BIT) @(negedge clk50);
  for (int i = 0; i < 8; i++) begin
    UART_RX = data[i]; // LSB first
    repeat (CLKS_PER_BIT) @(negedge clk50);
  end
  UART_RX = 1'b1; // Stop bit, then idle
  repeat (CLKS_PER_BIT) @(negedge clk50);
  while (!got && n < 4 * CLKS_PER_BIT) begin
    @(negedge clk50);
    n++;
    got = (mcpu_top_i.lod_bus.write_req === 1'b1) && (mcpu_top_i.lod_bus.ready === 1'b1);
  end
  if (!got) fail_timeout("a received UART byte was never written to memory");
  model_write(data);
endtask

task automatic peek_word(input logic [9:0] addr, input logic [31:0] want);
  int   n;
  logic got;
  n   = 0;
  got = 1'b0;
  @(negedge clk50);
  SW     = addr;
  KEY[1] = 1'b0; // Press
  while (!got && n < 16) begin
    @(negedge clk50);
    n++;
    got = (mcpu_top_i.peek_bus.read_valid === 1'b1);
  end
  if (!got) fail_timeout("a peek read never returned data");
  @(negedge clk50); // LEDs loaded on the read_valid edge
  KEY[1] = 1'b1;
  check_leds(addr, want);
  repeat (4) @(negedge clk50); // Release settles through the synchronizer
endtask

//--- verif/tb_mcpu.sv
`timescale 1ns/10ps

module tb_mcpu;

  localparam int CLKS_PER_BIT = 8;
  localparam int INIT_WORDS   = mcpu_bus_pkg::MEM_WORDS;
  localparam int MAX_CYCLES   = 40000; // Whole-run watchdog
  localparam int RX_BYTES     = 40;
  localparam int MIXED_BYTES  = 6;     // Bytes with a peek in flight
  localparam int RERUN_BYTES  = 10;

  // Press delay that puts the peek read on the byte's write cycle
  localparam int CLASH_DELAY  = 9 * CLKS_PER_BIT + CLKS_PER_BIT / 2 + 2;

  logic                 clk50;
  logic                 arst_n;
  mcpu_io_pkg::switch_t SW;
  logic [3:0]           KEY;      // Active low buttons
  logic                 UART_RX;
  mcpu_io_pkg::led_r_t  LEDR;
  mcpu_io_pkg::led_g_t  LEDG;
  logic                 mc_ready;

  // Reference memory
  logic [31:0] model_mem [1024];
  logic [11:0] model_ptr;  // Byte pointer with the lane in bits 1..0
  int          top_ptr;    // Highest pointer ever reached

  logic [31:0] rng_state;
  int          err_cnt;
  int          check_cnt;

  mcpu_top #(
    .clks_per_bit (CLKS_PER_BIT),
    .init_words   (INIT_WORDS)
  ) mcpu_top_i (
    .clk50    (clk50),
    .arst_n   (arst_n),
    .SW       (SW),
    .KEY      (KEY),
    .UART_RX  (UART_RX),
    .LEDR     (LEDR),
    .LEDG     (LEDG),
    .mc_ready (mc_ready)
  );

  always #50 clk50 = ~clk50; // 100 ns period

  `include "tb_tasks.svh"

  task automatic model_write(input logic [7:0] data);
    model_mem[model_ptr[11:2]][8*model_ptr[1:0] +: 8] = data; // Lane from the low bits
    model_ptr = model_ptr + 12'd1;
    if (int'(model_ptr) > top_ptr) top_ptr = int'(model_ptr);
  endtask

  task automatic check_leds(input logic [9:0] addr, input logic [31:0] want);
    check_cnt++;
    if (LEDR !== want[9:0] || LEDG !== want[17:10]) begin
      err_cnt++;
      $display("[FAIL] %0t: word %0d shows LEDR=%h LEDG=%h, expected %h %h",
        $time, addr, LEDR, LEDG, want[9:0], want[17:10]);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d  errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic fail_timeout(input string what);
    err_cnt++;
    $display("Timeout at %0t: %s", $time, what);
    end_run();
  endtask

  initial begin
    repeat (MAX_CYCLES) @(posedge clk50);
    fail_timeout("the run went past its cycle limit");
  end

  initial begin
    logic [31:0] r;
    logic [9:0]  peek_addr;
    logic [31:0] exp_w;
    int          delay;
    int          words;

    clk50     = 1'b0;
    arst_n    = 1'b0;
    SW        = '0;
    KEY       = 4'hF; // All released
    UART_RX   = 1'b1; // Idle line
    rng_state = 32'h48ac_abe7;
    err_cnt   = 0;
    check_cnt = 0;
    model_ptr = '0;
    top_ptr   = 0;
    for (int w = 0; w < 1024; w++) model_mem[w] = '0;

    repeat (16) @(negedge clk50);
    arst_n = 1'b1;

    // Reset state before the clearing sweep
    check_cnt++;
    if (LEDR !== '0 || LEDG !== '0 || mc_ready !== 1'b0) begin
      err_cnt++;
      $display("[FAIL] %0t: after reset LEDR=%h LEDG=%h mc_ready=%b, expected zeros",
        $time, LEDR, LEDG, mc_ready);
    end
    wait_mc_ready();
    wait_core_release();

    for (int k = 0; k < 8; k++) begin // Cleared words read zero
      r = next_random();
      peek_word(r[9:0], 32'h0);
    end

    // Streamed bytes followed by a peek of every touched word
    for (int k = 0; k < RX_BYTES; k++) begin
      r = next_random();
      send_byte(r[7:0]);
    end
    for (int w = 0; w < (top_ptr + 3) / 4; w++) peek_word(10'(w), model_mem[w]);

    // Peek while a byte is on the line
    for (int k = 0; k < MIXED_BYTES; k++) begin
      r         = next_random();
      words     = int'(model_ptr[11:2]);  // Stay below the word being written
      peek_addr = 10'(int'(r[25:16]) % words);
      exp_w     = model_mem[peek_addr];
      delay     = CLASH_DELAY - (k % 2);  // Even steps meet the write
      fork
        send_byte(r[7:0]);
        begin
          repeat (delay) @(negedge clk50);
          peek_word(peek_addr, exp_w);
        end
      join
    end
    for (int w = RX_BYTES / 4; w < (top_ptr + 3) / 4; w++) begin
      peek_word(10'(w), model_mem[w]);
    end

    // Client reset keeps memory and restarts the pointer
    pulse_core_reset();
    check_leds(10'd0, 32'h0);
    model_ptr = '0;
    for (int k = 0; k < RERUN_BYTES; k++) begin
      r = next_random();
      send_byte(r[7:0]);
    end
    for (int w = 0; w < (top_ptr + 3) / 4; w++) peek_word(10'(w), model_mem[w]);

    end_run();
  end

endmodule

//--- tb.f
+incdir+verif
hw/mcpu_bus_pkg.sv
hw/mcpu_io_pkg.sv
hw/mem_bus_if.sv
hw/mem_arbiter.sv
hw/mem_ctrl.sv
hw/uart_loader.sv
hw/led_peek.sv
hw/mcpu_top.sv
verif/tb_mcpu.sv

//--- Makefile
.PHONY: sim clean

# Build with Verilator, run, and pass only on the pass line
sim:
	verilator --binary --timing --assert --top-module tb_mcpu -f tb.f
	@out="$$(./obj_dir/Vtb_mcpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
